//--- Makefile
.PHONY: all run clean

all: run

obj_dir/Vtb_pad_frame: sources.f $(wildcard *.sv)
	verilator --binary --timing --assert -f sources.f --top-module tb_pad_frame -o Vtb_pad_frame

run: obj_dir/Vtb_pad_frame
	./obj_dir/Vtb_pad_frame > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- io_pad_mux.sv
/*
  Functional pad mux, purely combinational.
  Each pad takes out and oe from the source its select names. The pad input
  goes back only to that source, the other two see zero. PAD_OFF drives nothing.
*/
`timescale 1ns/1ps
`default_nettype none

module io_pad_mux #(
  parameter int N_IO = 48
) (
  input  pad_pkg::pad_func_e [N_IO-1:0] pad_sel_i,
  input  logic [N_IO-1:0]               perio_out_i,
  input  logic [N_IO-1:0]               perio_oe_i,
  input  logic [N_IO-1:0]               apbio_out_i,
  input  logic [N_IO-1:0]               apbio_oe_i,
  input  logic [N_IO-1:0]               fpgaio_out_i,
  input  logic [N_IO-1:0]               fpgaio_oe_i,
  input  logic [N_IO-1:0]               pad_in_i,
  output logic [N_IO-1:0]               func_out_o,
  output logic [N_IO-1:0]               func_oe_o,
  output logic [N_IO-1:0]               perio_in_o,
  output logic [N_IO-1:0]               apbio_in_o,
  output logic [N_IO-1:0]               fpgaio_in_o
);

  always_comb begin
    func_out_o  = '0;
    func_oe_o   = '0;
    perio_in_o  = '0;
    apbio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int p = 0; p < N_IO; p++) begin
      unique case (pad_sel_i[p])
        pad_pkg::PAD_PERIO: begin
          func_out_o[p] = perio_out_i[p];
          func_oe_o[p]  = perio_oe_i[p];
          perio_in_o[p] = pad_in_i[p];
        end
        pad_pkg::PAD_APBIO: begin
          func_out_o[p] = apbio_out_i[p];
          func_oe_o[p]  = apbio_oe_i[p];
          apbio_in_o[p] = pad_in_i[p];
        end
        pad_pkg::PAD_FPGAIO: begin
          func_out_o[p]  = fpgaio_out_i[p];
          func_oe_o[p]   = fpgaio_oe_i[p];
          fpgaio_in_o[p] = pad_in_i[p];
        end
        default: begin
          // pad off, all defaults stay low
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pad_frame_top.sv
/*
  Pad frame top. Selects come from the AXI4-Lite register block, stm_i hands
  the fixed test pads to the eFPGA test port. All pad paths are combinational,
  only the select registers and the AXI responses are clocked.
*/
`timescale 1ns/1ps
`default_nettype none

module pad_frame_top #(
  parameter int N_IO = 48
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                stm_i,
  input  logic [N_IO-1:0]                     io_in_i,
  output logic [N_IO-1:0]                     io_out_o,
  output logic [N_IO-1:0]                     io_oe_o,
  input  logic [N_IO-1:0]                     perio_out_i,
  input  logic [N_IO-1:0]                     perio_oe_i,
  output logic [N_IO-1:0]                     perio_in_o,
  input  logic [N_IO-1:0]                     apbio_out_i,
  input  logic [N_IO-1:0]                     apbio_oe_i,
  output logic [N_IO-1:0]                     apbio_in_o,
  input  logic [N_IO-1:0]                     fpgaio_out_i,
  input  logic [N_IO-1:0]                     fpgaio_oe_i,
  output logic [N_IO-1:0]                     fpgaio_in_o,
  input  logic [pad_pkg::TEST_OUT_W-1:0]      testio_i,
  output logic [pad_pkg::TEST_IN_W-1:0]       testio_o,
  input  logic [pad_pkg::AXI_ADDR_W-1:0]      s_axi_awaddr_i,
  input  logic                                s_axi_awvalid_i,
  output logic                                s_axi_awready_o,
  input  logic [pad_pkg::AXI_DATA_W-1:0]      s_axi_wdata_i,
  input  logic [3:0]                          s_axi_wstrb_i,
  input  logic                                s_axi_wvalid_i,
  output logic                                s_axi_wready_o,
  output pad_pkg::axi_resp_e                  s_axi_bresp_o,
  output logic                                s_axi_bvalid_o,
  input  logic                                s_axi_bready_i,
  input  logic [pad_pkg::AXI_ADDR_W-1:0]      s_axi_araddr_i,
  input  logic                                s_axi_arvalid_i,
  output logic                                s_axi_arready_o,
  output logic [pad_pkg::AXI_DATA_W-1:0]      s_axi_rdata_o,
  output pad_pkg::axi_resp_e                  s_axi_rresp_o,
  output logic                                s_axi_rvalid_o,
  input  logic                                s_axi_rready_i
);

  pad_pkg::pad_func_e [N_IO-1:0]      s_pad_sel;
  logic [N_IO-1:0]                    s_func_out;
  logic [N_IO-1:0]                    s_func_oe;
  logic [N_IO-1:0]                    s_test_out;
  logic [N_IO-1:0]                    s_test_oe;
  logic [N_IO-1:0]                    s_test_own;
  logic [pad_pkg::TEST_IN_W-2:0]      s_test_in;
  logic [N_IO-1:0]                    s_pad_in;  // pad inputs after test isolation

  pad_mux_regs #(.N_IO(N_IO)) u_pad_mux_regs (
    .clk_i, .rst_n_i,
    .s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
    .s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
    .s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
    .s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
    .s_axi_rdata_o, .s_axi_rresp_o, .s_axi_rvalid_o, .s_axi_rready_i,
    .pad_sel_o    (s_pad_sel)
  );

  io_pad_mux #(.N_IO(N_IO)) u_io_pad_mux (
    .pad_sel_i    (s_pad_sel),
    .perio_out_i, .perio_oe_i, .apbio_out_i, .apbio_oe_i,
    .fpgaio_out_i, .fpgaio_oe_i,
    .pad_in_i     (s_pad_in),
    .func_out_o   (s_func_out),
    .func_oe_o    (s_func_oe),
    .perio_in_o, .apbio_in_o, .fpgaio_in_o
  );

  stm_test_router #(.N_IO(N_IO)) u_stm_test_router (
    .testio_i,
    .pad_in_i     (io_in_i),  // raw pads, gating done in the output stage
    .test_out_o   (s_test_out),
    .test_oe_o    (s_test_oe),
    .test_own_o   (s_test_own),
    .test_in_o    (s_test_in)
  );

  pad_output_stage #(.N_IO(N_IO)) u_pad_output_stage (
    .stm_i,
    .func_out_i   (s_func_out),
    .func_oe_i    (s_func_oe),
    .test_out_i   (s_test_out),
    .test_oe_i    (s_test_oe),
    .test_own_i   (s_test_own),
    .test_in_i    (s_test_in),
    .io_in_i,
    .io_out_o, .io_oe_o,
    .pad_in_o     (s_pad_in),
    .testio_o
  );

endmodule

`default_nettype wire

//--- pad_mux_regs.sv
/*
  AXI4-Lite slave with the per-pad function selects.
  Word k holds pads 16k..16k+15, pad 16k in bits 1:0. Low two address bits ignored.
  One write and one read response outstanding at a time. Addresses past the
  last word answer SLVERR, writes are dropped and reads return zero.
*/
`timescale 1ns/1ps
`default_nettype none

module pad_mux_regs #(
  parameter int N_IO = 48
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [pad_pkg::AXI_ADDR_W-1:0]      s_axi_awaddr_i,
  input  logic                                s_axi_awvalid_i,
  output logic                                s_axi_awready_o,
  input  logic [pad_pkg::AXI_DATA_W-1:0]      s_axi_wdata_i,
  input  logic [3:0]                          s_axi_wstrb_i,
  input  logic                                s_axi_wvalid_i,
  output logic                                s_axi_wready_o,
  output pad_pkg::axi_resp_e                  s_axi_bresp_o,
  output logic                                s_axi_bvalid_o,
  input  logic                                s_axi_bready_i,
  input  logic [pad_pkg::AXI_ADDR_W-1:0]      s_axi_araddr_i,
  input  logic                                s_axi_arvalid_i,
  output logic                                s_axi_arready_o,
  output logic [pad_pkg::AXI_DATA_W-1:0]      s_axi_rdata_o,
  output pad_pkg::axi_resp_e                  s_axi_rresp_o,
  output logic                                s_axi_rvalid_o,
  input  logic                                s_axi_rready_i,
  output pad_pkg::pad_func_e [N_IO-1:0]       pad_sel_o
);

  localparam int PPW     = pad_pkg::PADS_PER_WORD;
  localparam int SEL_W   = pad_pkg::SEL_W;
  localparam int N_WORDS = (N_IO + PPW - 1) / PPW;
  localparam int WADDR_W = pad_pkg::AXI_ADDR_W - 2;

  pad_pkg::pad_func_e [N_IO-1:0]      sel_q;
  logic                               bvalid_q;
  logic                               rvalid_q;
  pad_pkg::axi_resp_e                 bresp_q;
  pad_pkg::axi_resp_e                 rresp_q;
  logic [pad_pkg::AXI_DATA_W-1:0]     rdata_q;
  logic [pad_pkg::AXI_DATA_W-1:0]     rdata_d;
  logic [WADDR_W-1:0]                 aw_word;
  logic [WADDR_W-1:0]                 ar_word;
  logic                               aw_err;
  logic                               ar_err;
  logic                               wr_hs;
  logic                               rd_hs;

  assign aw_word = s_axi_awaddr_i[pad_pkg::AXI_ADDR_W-1:2];
  assign ar_word = s_axi_araddr_i[pad_pkg::AXI_ADDR_W-1:2];
  assign aw_err  = (aw_word >= WADDR_W'(N_WORDS));
  assign ar_err  = (ar_word >= WADDR_W'(N_WORDS));

  // aw and w taken together, only while no b is pending
  assign wr_hs           = s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_q;
  assign s_axi_awready_o = wr_hs;
  assign s_axi_wready_o  = wr_hs;
  assign rd_hs           = s_axi_arvalid_i & ~rvalid_q;
  assign s_axi_arready_o = ~rvalid_q;

  // select array, byte strobes cover four pads each
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < N_IO; p++) begin
        sel_q[p] <= pad_pkg::PAD_PERIO;
      end
    end else if (wr_hs && !aw_err) begin
      for (int p = 0; p < N_IO; p++) begin
        if (aw_word == WADDR_W'(p / PPW) && s_axi_wstrb_i[(p % PPW) * SEL_W / 8]) begin
          sel_q[p] <= pad_pkg::pad_func_e'(s_axi_wdata_i[(p % PPW) * SEL_W +: SEL_W]);
        end
      end
    end
  end

  // read word gather, pads past N_IO stay zero
  always_comb begin
    rdata_d = '0;
    for (int p = 0; p < N_IO; p++) begin
      if (ar_word == WADDR_W'(p / PPW)) begin
        rdata_d[(p % PPW) * SEL_W +: SEL_W] = sel_q[p];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (s_axi_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (s_axi_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      bresp_q <= aw_err ? pad_pkg::RESP_SLVERR : pad_pkg::RESP_OKAY;
    end
    if (rd_hs) begin
      rdata_q <= rdata_d;  // captured at accept, held while stalled
      rresp_q <= ar_err ? pad_pkg::RESP_SLVERR : pad_pkg::RESP_OKAY;
    end
  end

  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = bresp_q;
  assign s_axi_rvalid_o = rvalid_q;
  assign s_axi_rresp_o  = rresp_q;
  assign s_axi_rdata_o  = rdata_q;
  assign pad_sel_o      = sel_q;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
    else $error("bvalid dropped before bready");

  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
    else $error("read response changed while stalled");

endmodule

`default_nettype wire

//--- pad_output_stage.sv
/*
  Final pad stage, selects functional or test path on stm_i.
  In test mode unowned pads are driven low with oe low, and the functional
  inputs read zero. testio_o carries the stm flag in its top bit.
*/
`timescale 1ns/1ps
`default_nettype none

module pad_output_stage #(
  parameter int N_IO = 48
) (
  input  logic                            stm_i,
  input  logic [N_IO-1:0]                 func_out_i,
  input  logic [N_IO-1:0]                 func_oe_i,
  input  logic [N_IO-1:0]                 test_out_i,
  input  logic [N_IO-1:0]                 test_oe_i,
  input  logic [N_IO-1:0]                 test_own_i,
  input  logic [pad_pkg::TEST_IN_W-2:0]   test_in_i,
  input  logic [N_IO-1:0]                 io_in_i,
  output logic [N_IO-1:0]                 io_out_o,
  output logic [N_IO-1:0]                 io_oe_o,
  output logic [N_IO-1:0]                 pad_in_o,
  output logic [pad_pkg::TEST_IN_W-1:0]   testio_o
);

  // owned pads from the router, everything else forced low
  assign io_out_o = stm_i ? (test_out_i & test_own_i) : func_out_i;
  assign io_oe_o  = stm_i ? (test_oe_i & test_own_i) : func_oe_i;

  assign pad_in_o = stm_i ? '0 : io_in_i;  // isolate the functional sources
  assign testio_o = stm_i ? {1'b1, test_in_i} : '0;

  // router must never enable a pad it does not own
  always_comb begin
    if (stm_i) begin
      assert ((test_oe_i & ~test_own_i) == '0)
        else $error("test path enables an unowned pad");
    end
  end

endmodule

`default_nettype wire

//--- pad_pkg.sv
/*
  Shared widths and encodings of the pad frame.
  The test-port sizes and TEST_PAD_MIN match the fixed eFPGA test map.
  Select encodings are the values software writes into the pad mux words.
*/
`default_nettype none

package pad_pkg;

  // one select per pad, 16 selects per 32-bit register word
  localparam int SEL_W         = 2;
  localparam int PADS_PER_WORD = 16;

  // register interface
  localparam int AXI_ADDR_W = 8;   // byte address, word aligned
  localparam int AXI_DATA_W = 32;

  // eFPGA test port
  localparam int TEST_OUT_W   = 16;  // test port to pads
  localparam int TEST_IN_W    = 21;  // pads to test port, top bit is the stm flag
  localparam int TEST_PAD_MIN = 43;  // highest test pad is 42

  // source that drives a pad
  typedef enum logic [SEL_W-1:0] {
    PAD_PERIO  = 2'd0,  // peripheral io, reset value
    PAD_APBIO  = 2'd1,  // apb gpio
    PAD_FPGAIO = 2'd2,  // efpga io
    PAD_OFF    = 2'd3   // pad not driven, input not returned
  } pad_func_e;

  // axi4-lite response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

//--- sources.f
pad_pkg.sv
pad_mux_regs.sv
io_pad_mux.sv
stm_test_router.sv
pad_output_stage.sv
pad_frame_top.sv
tb_pad_frame.sv

//--- stm_test_router.sv
/*
  Fixed map between the eFPGA test port and the test pads.
  Outputs are not gated here, the output stage applies the test-mode pin.
  Needs N_IO >= 43, the highest test pad is 42.
*/
`timescale 1ns/1ps
`default_nettype none

module stm_test_router #(
  parameter int N_IO = 48
) (
  input  logic [pad_pkg::TEST_OUT_W-1:0]  testio_i,
  input  logic [N_IO-1:0]                 pad_in_i,
  output logic [N_IO-1:0]                 test_out_o,
  output logic [N_IO-1:0]                 test_oe_o,
  output logic [N_IO-1:0]                 test_own_o,
  output logic [pad_pkg::TEST_IN_W-2:0]   test_in_o
);

  typedef enum logic [1:0] {
    ROLE_NONE,      // stays with the functional path
    ROLE_DATA,      // driven, enable from the test port
    ROLE_FORCE_EN,  // driven, enable tied high
    ROLE_INPUT      // only sampled by the test port
  } pad_role_e;

  function automatic pad_role_e role_of(input int p);
    if (p == 21 || (p >= 29 && p <= 36)) return ROLE_DATA;
    if (p == 22 || (p >= 37 && p <= 42)) return ROLE_FORCE_EN;
    if ((p >= 7 && p <= 12) || p == 23 || (p >= 25 && p <= 28)) return ROLE_INPUT;
    return ROLE_NONE;
  endfunction

  // test port bit that drives pad p, -1 for a constant zero
  function automatic int out_src(input int p);
    if (p >= 29 && p <= 36) return p - 29;  // pif do_l / do_h
    if (p >= 39 && p <= 42) return p - 31;  // spe out
    if (p == 21) return 14;                 // pif vldo
    return -1;
  endfunction

  // test port bit that enables a ROLE_DATA pad
  function automatic int oe_src(input int p);
    if (p >= 29 && p <= 32) return 12;
    if (p >= 33 && p <= 36) return 13;
    return 15;  // pad 21
  endfunction

  always_comb begin
    pad_role_e role;
    int        src;
    test_out_o = '0;
    test_oe_o  = '0;
    test_own_o = '0;
    for (int p = 0; p < N_IO; p++) begin
      role = role_of(p);
      src  = out_src(p);
      if (role == ROLE_DATA || role == ROLE_FORCE_EN) begin
        test_own_o[p] = 1'b1;
        test_out_o[p] = (src >= 0) ? testio_i[src] : 1'b0;
        test_oe_o[p]  = (role == ROLE_FORCE_EN) ? 1'b1 : testio_i[oe_src(p)];
      end
    end
  end

  assign test_in_o[3:0]   = pad_in_i[32:29];  // pif di_l
  assign test_in_o[7:4]   = pad_in_i[36:33];  // pif di_h
  assign test_in_o[11:8]  = pad_in_i[28:25];  // spe in
  assign test_in_o[17:12] = pad_in_i[12:7];   // mode bits M
  assign test_in_o[18]    = pad_in_i[23];     // mlatch
  assign test_in_o[19]    = pad_in_i[21];     // pif vldi

  always_comb begin
    assert (N_IO >= pad_pkg::TEST_PAD_MIN)
      else $error("N_IO %0d too small for the test map", N_IO);
  end

endmodule

`default_nettype wire

//--- tb_pad_frame.sv
/*
  Testbench for the pad frame top, N_IO fixed at 48.
  Pad, oe and input vectors are compared on every falling edge against a
  shadow copy of the selects. Random data comes from a seeded Galois LFSR.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pad_frame;

  localparam int N_IO           = 48;
  localparam int PPW            = pad_pkg::PADS_PER_WORD;
  localparam int N_WORDS        = (N_IO + PPW - 1) / PPW;
  localparam int ROUNDS         = 200;   // about 7 cycles each
  localparam int TIMEOUT_CYCLES = 3000;  // roughly twice the whole run

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             stm;
  logic [N_IO-1:0]                  io_in, io_out, io_oe;
  logic [N_IO-1:0]                  perio_out, perio_oe, perio_in;
  logic [N_IO-1:0]                  apbio_out, apbio_oe, apbio_in;
  logic [N_IO-1:0]                  fpgaio_out, fpgaio_oe, fpgaio_in;
  logic [pad_pkg::TEST_OUT_W-1:0]   testio_in;
  logic [pad_pkg::TEST_IN_W-1:0]    testio_out;
  logic [pad_pkg::AXI_ADDR_W-1:0]   awaddr, araddr;
  logic [pad_pkg::AXI_DATA_W-1:0]   wdata, rdata;
  logic [3:0]                       wstrb;
  logic                             awvalid, awready, wvalid, wready, bvalid, bready;
  logic                             arvalid, arready, rvalid, rready;
  pad_pkg::axi_resp_e               bresp, rresp;

  pad_pkg::pad_func_e               shadow_sel [N_IO];
  logic [31:0]                      lfsr = 32'h8339;
  int                               pad_errors = 0;
  int                               bus_errors = 0;
  int                               cycles = 0;

  pad_frame_top #(.N_IO(N_IO)) u_pad_frame_top (
    .clk_i(clk), .rst_n_i(rst_n), .stm_i(stm),
    .io_in_i(io_in), .io_out_o(io_out), .io_oe_o(io_oe),
    .perio_out_i(perio_out), .perio_oe_i(perio_oe), .perio_in_o(perio_in),
    .apbio_out_i(apbio_out), .apbio_oe_i(apbio_oe), .apbio_in_o(apbio_in),
    .fpgaio_out_i(fpgaio_out), .fpgaio_oe_i(fpgaio_oe), .fpgaio_in_o(fpgaio_in),
    .testio_i(testio_in), .testio_o(testio_out),
    .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
    .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
    .s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
    .s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
    .s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
    .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a bus handshake never completed", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // right shifting form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[b] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic shuffle_sources();
    logic [63:0] v;
    take_bits(N_IO, v);
    perio_out  = v[N_IO-1:0];
    take_bits(N_IO, v);
    perio_oe   = v[N_IO-1:0];
    take_bits(N_IO, v);
    apbio_out  = v[N_IO-1:0];
    take_bits(N_IO, v);
    apbio_oe   = v[N_IO-1:0];
    take_bits(N_IO, v);
    fpgaio_out = v[N_IO-1:0];
    take_bits(N_IO, v);
    fpgaio_oe  = v[N_IO-1:0];
    take_bits(N_IO, v);
    io_in      = v[N_IO-1:0];
    take_bits(pad_pkg::TEST_OUT_W, v);
    testio_in = v[pad_pkg::TEST_OUT_W-1:0];
  endtask

  // {oe, out} of pad p
  function automatic logic [1:0] ref_pad_out(input int p);
    if (stm) begin
      if (p == 21) return {testio_in[15], testio_in[14]};
      if (p >= 29 && p <= 32) return {testio_in[12], testio_in[p - 29]};
      if (p >= 33 && p <= 36) return {testio_in[13], testio_in[p - 29]};
      if (p >= 39 && p <= 42) return {1'b1, testio_in[p - 31]};
      if (p == 22 || p == 37 || p == 38) return 2'b10;  // enabled, driven low
      return 2'b00;
    end
    case (shadow_sel[p])
      pad_pkg::PAD_PERIO:  return {perio_oe[p], perio_out[p]};
      pad_pkg::PAD_APBIO:  return {apbio_oe[p], apbio_out[p]};
      pad_pkg::PAD_FPGAIO: return {fpgaio_oe[p], fpgaio_out[p]};
      default:             return 2'b00;
    endcase
  endfunction

  // {fpgaio, apbio, perio} input bits of pad p
  function automatic logic [2:0] ref_pad_in(input int p);
    if (stm) return 3'b000;
    case (shadow_sel[p])
      pad_pkg::PAD_PERIO:  return {2'b00, io_in[p]};
      pad_pkg::PAD_APBIO:  return {1'b0, io_in[p], 1'b0};
      pad_pkg::PAD_FPGAIO: return {io_in[p], 2'b00};
      default:             return 3'b000;
    endcase
  endfunction

  function automatic logic [pad_pkg::TEST_IN_W-1:0] ref_testio();
    logic [pad_pkg::TEST_IN_W-1:0] t;
    t = '0;
    if (stm) begin
      t[3:0]   = io_in[32:29];
      t[7:4]   = io_in[36:33];
      t[11:8]  = io_in[28:25];
      t[17:12] = io_in[12:7];
      t[18]    = io_in[23];
      t[19]    = io_in[21];
      t[20]    = 1'b1;  // test-mode flag
    end
    return t;
  endfunction

  function automatic logic [31:0] ref_word(input logic [7:0] addr);
    logic [31:0] w;
    int          p;
    w = '0;
    for (int k = 0; k < PPW; k++) begin
      p = int'(addr[7:2]) * PPW + k;
      if (int'(addr[7:2]) < N_WORDS && p < N_IO) w[2 * k +: 2] = shadow_sel[p];
    end
    return w;
  endfunction

  function automatic pad_pkg::axi_resp_e ref_resp(input logic [7:0] addr);
    return (int'(addr[7:2]) < N_WORDS) ? pad_pkg::RESP_OKAY : pad_pkg::RESP_SLVERR;
  endfunction

  task automatic check_pads(input logic [N_IO-1:0] got, input logic [N_IO-1:0] exp,
                            input string what);
    if (got !== exp) begin
      pad_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_testio(input logic [pad_pkg::TEST_IN_W-1:0] got,
                              input logic [pad_pkg::TEST_IN_W-1:0] exp);
    if (got !== exp) begin
      pad_errors++;
      $display("FAILED at %0t: testio_o is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_resp(input pad_pkg::axi_resp_e got, input pad_pkg::axi_resp_e exp,
                            input string what);
    if (got !== exp) begin
      bus_errors++;
      $display("FAILED at %0t: %s response %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_rdata(input logic [pad_pkg::AXI_DATA_W-1:0] got,
                             input logic [pad_pkg::AXI_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      bus_errors++;
      $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // pads are stable at the falling edge
  always @(negedge clk) begin
    logic [N_IO-1:0] exp_out, exp_oe, exp_per, exp_apb, exp_fpga;
    logic [1:0]      drv;
    logic [2:0]      pin;
    if (rst_n) begin
      for (int p = 0; p < N_IO; p++) begin
        drv = ref_pad_out(p);
        pin = ref_pad_in(p);
        {exp_oe[p], exp_out[p]} = drv;
        {exp_fpga[p], exp_apb[p], exp_per[p]} = pin;
      end
      check_pads(io_out, exp_out, "io_out_o");
      check_pads(io_oe, exp_oe, "io_oe_o");
      check_pads(perio_in, exp_per, "perio_in_o");
      check_pads(apbio_in, exp_apb, "apbio_in_o");
      check_pads(fpgaio_in, exp_fpga, "fpgaio_in_o");
      check_testio(testio_out, ref_testio());
    end
  end

  // bus tasks start and end 1 ns after a rising edge
  task automatic drive_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
  endtask

  task automatic finish_write();
    int p;
    @(negedge clk);
    while (!awready) @(negedge clk);
    if (!wready) begin
      bus_errors++;
      $display("wready stayed low while awready was high");
    end
    @(posedge clk);
    #1;
    for (int k = 0; k < PPW; k++) begin
      p = int'(awaddr[7:2]) * PPW + k;
      if (int'(awaddr[7:2]) < N_WORDS && p < N_IO && wstrb[k / 4]) begin
        shadow_sel[p] = pad_pkg::pad_func_e'(wdata[2 * k +: 2]);
      end
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic take_bresp(output pad_pkg::axi_resp_e resp);
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic drive_read(input logic [7:0] addr);
    araddr  = addr;
    arvalid = 1'b1;
  endtask

  task automatic finish_read();
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  task automatic take_rresp(output logic [31:0] data, output pad_pkg::axi_resp_e resp);
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    pad_pkg::axi_resp_e resp;
    drive_write(addr, data, strb);
    finish_write();
    take_bresp(resp);
    check_resp(resp, ref_resp(addr), "write");
  endtask

  task automatic read_check(input logic [7:0] addr);
    pad_pkg::axi_resp_e          resp;
    logic [31:0]                 data;
    logic [31:0]                 exp;
    exp = ref_word(addr);  // selects at accept time
    drive_read(addr);
    finish_read();
    take_rresp(data, resp);
    check_resp(resp, ref_resp(addr), "read");
    check_rdata(data, exp, "select word");
  endtask

  task automatic read_all_words();
    for (int w = 0; w < N_WORDS; w++) begin
      read_check(8'(w * 4));
    end
  endtask

  initial begin
    logic [63:0]        v;
    logic [7:0]         addr;
    logic [31:0]        data;
    logic [31:0]        exp;
    pad_pkg::axi_resp_e resp;
    rst_n   = 1'b0;
    stm     = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    shuffle_sources();
    foreach (shadow_sel[p]) shadow_sel[p] = pad_pkg::PAD_PERIO;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // after reset every pad follows peripheral io
    read_all_words();
    repeat (4) begin
      @(posedge clk);
      #1;
      shuffle_sources();
    end

    // random selects with partial strobes
    for (int r = 0; r < ROUNDS; r++) begin
      take_bits(2, v);
      addr = 8'((int'(v[1:0]) % N_WORDS) * 4);
      take_bits(32, v);
      data = v[31:0];
      take_bits(4, v);
      write_check(addr, data, v[3:0]);
      read_check(addr);
      repeat (3) begin
        @(posedge clk);
        #1;
        shuffle_sources();
      end
    end

    // out of range words, 0x80 aliases word 0 if upper address bits are lost
    take_bits(32, v);
    write_check(8'(N_WORDS * 4), v[31:0], 4'hf);
    write_check(8'h80, ~v[31:0], 4'hf);
    read_check(8'(N_WORDS * 4));
    read_check(8'h80);
    read_all_words();

    // test mode owns the fixed pads
    stm = 1'b1;
    repeat (20) begin
      @(posedge clk);
      #1;
      shuffle_sources();
    end
    stm = 1'b0;
    repeat (4) begin
      @(posedge clk);
      #1;
      shuffle_sources();
    end

    // second write held off by a stalled B
    take_bits(32, v);
    drive_write(8'h00, v[31:0], 4'hf);
    finish_write();
    drive_write(8'h04, ~v[31:0], 4'h5);
    repeat (4) begin
      @(negedge clk);
      if (awready || wready || !bvalid) begin
        bus_errors++;
        $display("write was accepted while the B response was stalled");
      end
    end
    @(posedge clk);
    #1;
    take_bresp(resp);
    check_resp(resp, pad_pkg::RESP_OKAY, "stalled write");
    finish_write();
    take_bresp(resp);
    check_resp(resp, pad_pkg::RESP_OKAY, "second write");

    // second read held off by a stalled R
    exp = ref_word(8'h08);
    drive_read(8'h08);
    finish_read();
    drive_read(8'h04);
    repeat (4) begin
      @(negedge clk);
      if (arready) begin
        bus_errors++;
        $display("read was accepted while the R response was stalled");
      end
      check_rdata(rdata, exp, "stalled read");
    end
    @(posedge clk);
    #1;
    exp = ref_word(8'h08);
    take_rresp(data, resp);
    check_resp(resp, pad_pkg::RESP_OKAY, "stalled read");
    check_rdata(data, exp, "stalled read");
    exp = ref_word(8'h04);
    finish_read();
    take_rresp(data, resp);
    check_resp(resp, pad_pkg::RESP_OKAY, "second read");
    check_rdata(data, exp, "second read");
    read_all_words();

    repeat (2) @(posedge clk);
    $display("pad errors %0d, bus errors %0d", pad_errors, bus_errors);
    if (pad_errors == 0 && bus_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
